// File: mport.f
+incdir+bench
hw/mport_pkg.sv
hw/port_arbiter.sv
hw/refresh_sched.sv
hw/bank_unit.sv
hw/read_return.sv
hw/mport_top.sv
bench/mport_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mport_tb
FILELIST  ?= mport.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test passed

SOURCES := $(wildcard hw/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mport_tests.svh
`ifndef MPORT_TESTS_SVH
`define MPORT_TESTS_SVH

  typedef struct packed {
    logic [31:0]      due;  // cycle the reply must show up
    mport_pkg::data_t data;
    mport_pkg::padr_t padr;
  } exp_t;

  mport_pkg::data_t model [512];  // reference copy of the memory
  exp_t             exp_q [mport_pkg::NUM_PORTS][$];

  // user address is {row, bank, word}
  function automatic mport_pkg::addr_t make_addr(input int row, input int bank, input int word);
    return {4'(row), 3'(bank), 2'(word)};
  endfunction

  function automatic mport_pkg::padr_t phys_addr(input mport_pkg::addr_t a);
    return {a[4:2], a[8:5], a[1:0]};  // bank, row, word
  endfunction

  function automatic mport_pkg::data_t fill_word(input mport_pkg::addr_t a);
    return {7'h5a, a, 7'h33, ~a};
  endfunction

  task automatic record_accept(input int p);
    mport_pkg::addr_t a;
    exp_t             e;
    a = req_addr[p];
    if (req_write[p]) begin
      model[a] = req_din[p];
    end else begin
      e.due  = 32'(cycle + mport_pkg::READ_LATENCY);
      e.data = model[a];
      e.padr = phys_addr(a);
      exp_q[p].push_back(e);
    end
  endtask

  task automatic check_port_reply(input int p);
    exp_t e;
    if (rd_vld[p]) begin
      if (exp_q[p].size() == 0) begin
        stop_on_error($sformatf("port %0d returned read data with no read pending", p));
      end
      e = exp_q[p].pop_front();
      check_eq($sformatf("rd_vld[%0d] cycle", p), 32'(cycle), e.due);
      check_eq($sformatf("rd_dout[%0d]", p), rd_dout[p], e.data);
      check_eq($sformatf("rd_padr[%0d]", p), 32'(rd_padr[p]), 32'(e.padr));
    end else if (exp_q[p].size() != 0 && 32'(cycle) >= exp_q[p][0].due) begin
      stop_on_error($sformatf("port %0d read reply did not arrive in time", p));
    end
  endtask

  // starts on a rising edge, returns on the edge that accepts
  task automatic send_request(input int p, input logic wr, input mport_pkg::addr_t a,
                              input mport_pkg::data_t d);
    int waited;
    waited = 0;
    req_valid[p] <= 1'b1;
    req_write[p] <= wr;
    req_addr[p]  <= a;
    req_din[p]   <= d;
    @(negedge clk);
    while (!req_ready[p]) begin
      waited++;
      if (waited > 32) stop_on_error($sformatf("port %0d never became ready", p));
      @(negedge clk);
    end
    @(posedge clk);
    req_valid[p] <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      waited++;
      if (waited > 16) stop_on_error("pending reads never drained");
      @(posedge clk);
    end
  endtask

  task automatic wait_refresh_end();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 2 * REF_INTERVAL) stop_on_error("no refresh pulse seen");
    end while (!refr_vld);
    @(posedge clk);
  endtask

  task automatic test_write_read();
    mport_pkg::addr_t a;
    for (int p = 0; p < mport_pkg::NUM_PORTS; p++) begin
      a = make_addr(3 + p, 5, 2 - p);
      send_request(p, 1'b1, a, 32'hc0de_0000 + 32'(p));
      send_request(p, 1'b0, a, '0);
      wait_drain();
    end
  endtask

  task automatic test_word_align();
    for (int w = 3; w >= 0; w--) begin
      send_request(0, 1'b1, make_addr(9, 2, w), 32'h1111_1111 * 32'(w + 1));
    end
    for (int w = 0; w < 4; w++) send_request(1, 1'b0, make_addr(9, 2, w), '0);
    wait_drain();
  endtask

  task automatic test_bank_conflict();
    wait_refresh_end();  // next refresh is a full interval away
    req_valid   <= 2'b11;
    req_write   <= 2'b11;
    req_addr[0] <= make_addr(1, 6, 0);
    req_addr[1] <= make_addr(2, 6, 1);
    req_din[0]  <= 32'haaaa_0001;
    req_din[1]  <= 32'hbbbb_0002;
    @(negedge clk);
    check_eq("req_ready[0]", 32'(req_ready[0]), 32'd1);
    check_eq("req_ready[1]", 32'(req_ready[1]), 32'd0);
    @(posedge clk);
    req_valid[0] <= 1'b0;
    @(negedge clk);
    check_eq("req_ready[1]", 32'(req_ready[1]), 32'd1);
    @(posedge clk);
    req_valid   <= 2'b11;  // different banks now
    req_addr[0] <= make_addr(1, 3, 0);
    req_addr[1] <= make_addr(1, 4, 0);
    @(negedge clk);
    check_eq("req_ready[0]", 32'(req_ready[0]), 32'd1);
    check_eq("req_ready[1]", 32'(req_ready[1]), 32'd1);
    @(posedge clk);
    req_valid <= 2'b00;
    send_request(0, 1'b0, make_addr(2, 6, 1), '0);
    send_request(1, 1'b0, make_addr(1, 6, 0), '0);
    wait_drain();
  endtask

  task automatic test_refresh();
    int   since;
    logic pulse;
    // long enough for the bank index to wrap
    for (int n = 0; n < (mport_pkg::NUM_BANKS + 1) * REF_INTERVAL; n++) begin
      @(negedge clk);
      since = cycle - RESET_CYCLES;
      pulse = (since > 0) && (since % REF_INTERVAL == 0);
      check_eq("refr_vld", 32'(refr_vld), 32'(pulse));
      if (pulse) begin
        check_eq("refr_bank", 32'(refr_bank),
                 32'((since / REF_INTERVAL - 1) % mport_pkg::NUM_BANKS));
      end
    end
    // aim a write at the bank of the next pulse
    while ((cycle + 1 - RESET_CYCLES) % REF_INTERVAL != 0) @(negedge clk);
    since = cycle + 1 - RESET_CYCLES;
    @(posedge clk);
    req_valid[0] <= 1'b1;
    req_write[0] <= 1'b1;
    req_addr[0]  <= make_addr(7, (since / REF_INTERVAL - 1) % mport_pkg::NUM_BANKS, 3);
    req_din[0]   <= 32'hfeed_0007;
    @(negedge clk);
    check_eq("refr_vld", 32'(refr_vld), 32'd1);
    check_eq("req_ready[0]", 32'(req_ready[0]), 32'd0);
    @(negedge clk);
    check_eq("req_ready[0]", 32'(req_ready[0]), 32'd1);
    @(posedge clk);
    req_valid[0] <= 1'b0;
  endtask

  // port 0 owns even banks, port 1 odd ones
  task automatic fill_memory();
    fork
      for (int i = 0; i < 256; i++) begin
        send_request(0, 1'b1, {i[7:2], 1'b0, i[1:0]}, fill_word({i[7:2], 1'b0, i[1:0]}));
      end
      for (int i = 0; i < 256; i++) begin
        send_request(1, 1'b1, {i[7:2], 1'b1, i[1:0]}, fill_word({i[7:2], 1'b1, i[1:0]}));
      end
    join
  endtask

  task automatic random_traffic(input int p);
    logic wr;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      if (lfsr_bits(2) == 0) begin
        @(posedge clk);  // idle
      end else begin
        wr = lfsr_bits(1) != 0;
        send_request(p, wr, mport_pkg::addr_t'(lfsr_bits(9)), lfsr_bits(32));
      end
    end
  endtask

  task automatic test_random();
    fill_memory();
    fork
      random_traffic(0);
      random_traffic(1);
    join
    wait_drain();
  endtask

`endif

// File: bench/mport_tb.sv
module mport_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int REF_INTERVAL = 16;
  localparam int RANDOM_OPS   = 300;

  // cycle budget of each test, summed for the watchdog
  localparam int WRITE_READ_CYCLES = 30;
  localparam int ALIGN_CYCLES      = 30;
  localparam int CONFLICT_CYCLES   = 2 * REF_INTERVAL + 20;
  localparam int REFRESH_CYCLES    = (mport_pkg::NUM_BANKS + 2) * REF_INTERVAL + 10;
  localparam int RANDOM_CYCLES     = 300 + 3 * RANDOM_OPS;  // fill plus traffic
  localparam int WATCHDOG_CYCLES   = RESET_CYCLES + 2 * (WRITE_READ_CYCLES + ALIGN_CYCLES
                                     + CONFLICT_CYCLES + REFRESH_CYCLES + RANDOM_CYCLES);

  logic                            clk = 1'b0;
  logic                            reset;
  logic [mport_pkg::NUM_PORTS-1:0] req_valid;
  logic [mport_pkg::NUM_PORTS-1:0] req_write;
  mport_pkg::addr_t                req_addr [mport_pkg::NUM_PORTS];
  mport_pkg::data_t                req_din [mport_pkg::NUM_PORTS];
  logic [mport_pkg::NUM_PORTS-1:0] req_ready;
  logic [mport_pkg::NUM_PORTS-1:0] rd_vld;
  mport_pkg::data_t                rd_dout [mport_pkg::NUM_PORTS];
  mport_pkg::padr_t                rd_padr [mport_pkg::NUM_PORTS];
  logic                            refr_vld;
  mport_pkg::bank_t                refr_bank;

  int          cycle = 0;  // posedges since time zero
  logic [31:0] lfsr_state = 32'hd793;

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  mport_top #(
    .REF_INTERVAL (REF_INTERVAL)
  ) u_mport_top (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_din   (req_din),
    .req_ready (req_ready),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr),
    .refr_vld  (refr_vld),
    .refr_bank (refr_bank)
  );

  // galois lfsr, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;
      val = {val[30:0], out};
    end
    return val;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at cycle %0d", cycle);
  endtask

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

`include "mport_tests.svh"

  // replies checked before new acceptances are logged
  always @(negedge clk) begin
    if (!reset) begin
      for (int p = 0; p < mport_pkg::NUM_PORTS; p++) begin
        check_port_reply(p);
        if (req_valid[p] && req_ready[p]) record_accept(p);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_on_error($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    reset     = 1'b1;
    req_valid = '0;
    req_write = '0;
    for (int p = 0; p < mport_pkg::NUM_PORTS; p++) begin
      req_addr[p] = '0;
      req_din[p]  = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    test_write_read();
    test_word_align();
    test_bank_conflict();
    test_refresh();
    test_random();
    if (exp_q[0].size() == 0 && exp_q[1].size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      stop_on_error("reads still pending at the end of the run");
    end
  end

endmodule

// File: hw/mport_top.sv
module mport_top #(
  parameter int REF_INTERVAL = 16
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [mport_pkg::NUM_PORTS-1:0] req_valid,
  input  logic [mport_pkg::NUM_PORTS-1:0] req_write,
  input  mport_pkg::addr_t                req_addr [mport_pkg::NUM_PORTS],
  input  mport_pkg::data_t                req_din [mport_pkg::NUM_PORTS],
  output logic [mport_pkg::NUM_PORTS-1:0] req_ready,
  output logic [mport_pkg::NUM_PORTS-1:0] rd_vld,
  output mport_pkg::data_t                rd_dout [mport_pkg::NUM_PORTS],
  output mport_pkg::padr_t                rd_padr [mport_pkg::NUM_PORTS],
  output logic                            refr_vld,
  output mport_pkg::bank_t                refr_bank
);

  logic [mport_pkg::NUM_BANKS-1:0] bank_en;
  logic [mport_pkg::NUM_BANKS-1:0] bank_we;
  mport_pkg::row_t                 bank_row [mport_pkg::NUM_BANKS];
  mport_pkg::word_t                bank_word [mport_pkg::NUM_BANKS];
  mport_pkg::data_t                bank_din [mport_pkg::NUM_BANKS];
  mport_pkg::data_t                bank_dout [mport_pkg::NUM_BANKS];

  logic [mport_pkg::NUM_PORTS-1:0] read_port_valid;
  mport_pkg::bank_t                read_port_bank [mport_pkg::NUM_PORTS];
  mport_pkg::padr_t                read_port_padr [mport_pkg::NUM_PORTS];

  port_arbiter u_port_arbiter (
    .req_valid       (req_valid),
    .req_write       (req_write),
    .req_addr        (req_addr),
    .req_din         (req_din),
    .refr_vld        (refr_vld),
    .refr_bank       (refr_bank),
    .req_ready       (req_ready),
    .bank_en         (bank_en),
    .bank_we         (bank_we),
    .bank_row        (bank_row),
    .bank_word       (bank_word),
    .bank_din        (bank_din),
    .bank_port       (),  // owner per bank, kept inside the arbiter
    .read_port_valid (read_port_valid),
    .read_port_bank  (read_port_bank)
  );

  refresh_sched #(
    .REF_INTERVAL (REF_INTERVAL)
  ) u_refresh_sched (
    .clk       (clk),
    .reset     (reset),
    .refr_vld  (refr_vld),
    .refr_bank (refr_bank)
  );

  for (genvar b = 0; b < mport_pkg::NUM_BANKS; b++) begin : g_bank
    bank_unit #(
      .BANK_ID (b)
    ) u_bank_unit (
      .clk       (clk),
      .bank_en   (bank_en[b]),
      .bank_we   (bank_we[b]),
      .bank_row  (bank_row[b]),
      .bank_word (bank_word[b]),
      .bank_din  (bank_din[b]),
      .refr_vld  (refr_vld),
      .refr_bank (refr_bank),
      .bank_dout (bank_dout[b])
    );
  end

  // physical address is {bank, row, word}
  for (genvar p = 0; p < mport_pkg::NUM_PORTS; p++) begin : g_padr
    assign read_port_padr[p] = {req_addr[p][mport_pkg::BANK_LSB +: mport_pkg::BANK_BITS],
                                req_addr[p][mport_pkg::ROW_LSB +: mport_pkg::ROW_BITS],
                                req_addr[p][mport_pkg::WORD_LSB +: mport_pkg::WORD_BITS]};
  end

  read_return u_read_return (
    .clk             (clk),
    .reset           (reset),
    .read_port_valid (read_port_valid),
    .read_port_bank  (read_port_bank),
    .read_port_padr  (read_port_padr),
    .bank_dout       (bank_dout),
    .rd_vld          (rd_vld),
    .rd_dout         (rd_dout),
    .rd_padr         (rd_padr)
  );

endmodule

// File: hw/read_return.sv
module read_return (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [mport_pkg::NUM_PORTS-1:0] read_port_valid,
  input  mport_pkg::bank_t                read_port_bank [mport_pkg::NUM_PORTS],
  input  mport_pkg::padr_t                read_port_padr [mport_pkg::NUM_PORTS],
  input  mport_pkg::data_t                bank_dout [mport_pkg::NUM_BANKS],
  output logic [mport_pkg::NUM_PORTS-1:0] rd_vld,
  output mport_pkg::data_t                rd_dout [mport_pkg::NUM_PORTS],
  output mport_pkg::padr_t                rd_padr [mport_pkg::NUM_PORTS]
);

  logic [mport_pkg::NUM_PORTS-1:0] vld_q;  // lines up with bank_dout
  mport_pkg::bank_t bank_q [mport_pkg::NUM_PORTS];
  mport_pkg::padr_t padr_q [mport_pkg::NUM_PORTS];

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q  <= '0;
      rd_vld <= '0;
    end else begin
      vld_q  <= read_port_valid;
      rd_vld <= vld_q;
    end
  end

  // capture at acceptance
  always_ff @(posedge clk) begin
    for (int p = 0; p < mport_pkg::NUM_PORTS; p++) begin
      if (read_port_valid[p]) begin
        bank_q[p] <= read_port_bank[p];
        padr_q[p] <= read_port_padr[p];
      end
    end
  end

  // pick the bank word for each port
  always_ff @(posedge clk) begin
    for (int p = 0; p < mport_pkg::NUM_PORTS; p++) begin
      if (vld_q[p]) begin
        rd_dout[p] <= bank_dout[bank_q[p]];
        rd_padr[p] <= padr_q[p];
      end
    end
  end

  for (genvar p = 0; p < mport_pkg::NUM_PORTS; p++) begin : g_lat_chk
    rd_vld_latency: assert property (@(posedge clk) disable iff (reset)
      rd_vld[p] |-> $past(read_port_valid[p], mport_pkg::READ_LATENCY)
        && rd_padr[p][mport_pkg::PADR_BITS-1 -: mport_pkg::BANK_BITS]
           == $past(read_port_bank[p], mport_pkg::READ_LATENCY))
      else $error("port %0d read reply without matching acceptance", p);
  end

endmodule

// File: hw/bank_unit.sv
module bank_unit #(
  parameter int BANK_ID = 0
) (
  input  logic             clk,
  input  logic             bank_en,
  input  logic             bank_we,
  input  mport_pkg::row_t  bank_row,
  input  mport_pkg::word_t bank_word,
  input  mport_pkg::data_t bank_din,
  input  logic             refr_vld,
  input  mport_pkg::bank_t refr_bank,
  output mport_pkg::data_t bank_dout
);

  localparam mport_pkg::bank_t MY_BANK = mport_pkg::BANK_BITS'(BANK_ID);

  mport_pkg::row_data_t mem [mport_pkg::ROWS_PER_BANK];

  mport_pkg::row_data_t wr_mask;  // bit-write mask for one word
  mport_pkg::row_data_t wr_data;
  mport_pkg::row_data_t rd_row;
  mport_pkg::data_t     rd_word;

  always_comb begin
    wr_mask = mport_pkg::row_data_t'({mport_pkg::DATA_BITS{1'b1}})
              << (bank_word * mport_pkg::DATA_BITS);
    wr_data = {mport_pkg::WORDS_PER_ROW{bank_din}};  // word replicated into every lane
  end

  assign rd_row  = mem[bank_row];
  assign rd_word = rd_row[bank_word * mport_pkg::DATA_BITS +: mport_pkg::DATA_BITS];

  // full row write, only masked bits change
  always_ff @(posedge clk) begin
    if (bank_en && bank_we) begin
      mem[bank_row] <= (rd_row & ~wr_mask) | (wr_data & wr_mask);
    end
  end

  // word select registered at the acceptance edge
  always_ff @(posedge clk) begin
    if (bank_en && !bank_we) begin
      bank_dout <= rd_word;
    end
  end

  // refresh scheduler and arbiter together keep traffic off a refreshing bank
  no_access_in_refresh: assert property (@(posedge clk)
    !(bank_en && refr_vld && refr_bank == MY_BANK))
    else $error("bank %0d accessed during refresh", BANK_ID);

endmodule

// File: hw/refresh_sched.sv
module refresh_sched #(
  parameter int REF_INTERVAL = 16
) (
  input  logic             clk,
  input  logic             reset,
  output logic             refr_vld,
  output mport_pkg::bank_t refr_bank
);

  localparam int CNT_BITS = (REF_INTERVAL > 2) ? $clog2(REF_INTERVAL) : 1;
  localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(REF_INTERVAL - 1);
  localparam mport_pkg::bank_t BANK_LAST = mport_pkg::BANK_BITS'(mport_pkg::NUM_BANKS - 1);

  logic [CNT_BITS-1:0] interval_cnt;
  logic                interval_done;

  assign interval_done = (interval_cnt == CNT_LAST);

  // interval counter runs from reset
  always_ff @(posedge clk) begin
    if (reset) begin
      interval_cnt <= '0;
    end else if (interval_done) begin
      interval_cnt <= '0;
    end else begin
      interval_cnt <= interval_cnt + 1'b1;
    end
  end

  // pulse lands in the cycle after the last count
  always_ff @(posedge clk) begin
    if (reset) begin
      refr_vld <= 1'b0;
    end else begin
      refr_vld <= interval_done;
    end
  end

  // bank pointer moves on once its refresh is done
  always_ff @(posedge clk) begin
    if (reset) begin
      refr_bank <= '0;
    end else if (refr_vld) begin
      refr_bank <= (refr_bank == BANK_LAST) ? '0 : refr_bank + 1'b1;
    end
  end

  refr_single_cycle: assert property (@(posedge clk) disable iff (reset)
    refr_vld |=> !refr_vld)
    else $error("refresh held for more than one cycle");

endmodule

// File: hw/port_arbiter.sv
module port_arbiter (
  input  logic [mport_pkg::NUM_PORTS-1:0]       req_valid,
  input  logic [mport_pkg::NUM_PORTS-1:0]       req_write,
  input  mport_pkg::addr_t                      req_addr [mport_pkg::NUM_PORTS],
  input  mport_pkg::data_t                      req_din [mport_pkg::NUM_PORTS],
  input  logic                                  refr_vld,
  input  mport_pkg::bank_t                      refr_bank,
  output logic [mport_pkg::NUM_PORTS-1:0]       req_ready,
  output logic [mport_pkg::NUM_BANKS-1:0]       bank_en,
  output logic [mport_pkg::NUM_BANKS-1:0]       bank_we,
  output mport_pkg::row_t                       bank_row [mport_pkg::NUM_BANKS],
  output mport_pkg::word_t                      bank_word [mport_pkg::NUM_BANKS],
  output mport_pkg::data_t                      bank_din [mport_pkg::NUM_BANKS],
  output logic [$clog2(mport_pkg::NUM_PORTS)-1:0] bank_port [mport_pkg::NUM_BANKS],
  output logic [mport_pkg::NUM_PORTS-1:0]       read_port_valid,
  output mport_pkg::bank_t                      read_port_bank [mport_pkg::NUM_PORTS]
);

  localparam int PORT_BITS = $clog2(mport_pkg::NUM_PORTS);

  mport_pkg::bank_t req_bank [mport_pkg::NUM_PORTS];
  mport_pkg::row_t  req_row  [mport_pkg::NUM_PORTS];
  mport_pkg::word_t req_word [mport_pkg::NUM_PORTS];
  logic [mport_pkg::NUM_BANKS-1:0] grant [mport_pkg::NUM_PORTS];  // one-hot bank per port

  always_comb begin
    for (int p = 0; p < mport_pkg::NUM_PORTS; p++) begin
      req_bank[p] = req_addr[p][mport_pkg::BANK_LSB +: mport_pkg::BANK_BITS];
      req_row[p]  = req_addr[p][mport_pkg::ROW_LSB +: mport_pkg::ROW_BITS];
      req_word[p] = req_addr[p][mport_pkg::WORD_LSB +: mport_pkg::WORD_BITS];
    end
  end

  // lower port index has priority on a shared bank
  always_comb begin
    for (int p = 0; p < mport_pkg::NUM_PORTS; p++) begin
      req_ready[p] = !(refr_vld && req_bank[p] == refr_bank);
      for (int q = 0; q < p; q++) begin
        if (req_valid[q] && req_bank[q] == req_bank[p]) begin
          req_ready[p] = 1'b0;
        end
      end
      grant[p] = '0;
      grant[p][req_bank[p]] = req_valid[p] & req_ready[p];
      read_port_valid[p] = req_valid[p] & req_ready[p] & ~req_write[p];
      read_port_bank[p]  = req_bank[p];
    end
  end

  // steer the winning port onto each bank
  always_comb begin
    for (int b = 0; b < mport_pkg::NUM_BANKS; b++) begin
      bank_en[b]   = 1'b0;
      bank_port[b] = '0;
      for (int p = 0; p < mport_pkg::NUM_PORTS; p++) begin
        if (grant[p][b]) begin
          bank_en[b]   = 1'b1;
          bank_port[b] = PORT_BITS'(p);
        end
      end
      bank_we[b]   = bank_en[b] & req_write[bank_port[b]];
      bank_row[b]  = req_row[bank_port[b]];
      bank_word[b] = req_word[bank_port[b]];
      bank_din[b]  = req_din[bank_port[b]];
    end
  end

  // ready rule and steering together must never hand one bank to two ports
  always_comb begin : grant_check
    logic [mport_pkg::NUM_PORTS-1:0] claims;
    for (int b = 0; b < mport_pkg::NUM_BANKS; b++) begin
      for (int p = 0; p < mport_pkg::NUM_PORTS; p++) begin
        claims[p] = grant[p][b];
      end
      assert ($onehot0(claims))
        else $error("bank %0d granted to more than one port", b);
    end
  end

endmodule

// File: hw/mport_pkg.sv
package mport_pkg;

  localparam int NUM_PORTS     = 2;
  localparam int NUM_BANKS     = 8;
  localparam int ROWS_PER_BANK = 16;
  localparam int WORDS_PER_ROW = 4;

  localparam int DATA_BITS     = 32;
  localparam int ROW_DATA_BITS = DATA_BITS * WORDS_PER_ROW;
  localparam int BANK_BITS     = $clog2(NUM_BANKS);
  localparam int ROW_BITS      = $clog2(ROWS_PER_BANK);
  localparam int WORD_BITS     = $clog2(WORDS_PER_ROW);
  localparam int ADDR_BITS     = ROW_BITS + BANK_BITS + WORD_BITS;
  localparam int PADR_BITS     = BANK_BITS + ROW_BITS + WORD_BITS;

  // user address is {row, bank, word}
  localparam int WORD_LSB = 0;
  localparam int BANK_LSB = WORD_LSB + WORD_BITS;
  localparam int ROW_LSB  = BANK_LSB + BANK_BITS;

  localparam int READ_LATENCY = 2;  // acceptance to rd_vld

  typedef logic [DATA_BITS-1:0]     data_t;
  typedef logic [ROW_DATA_BITS-1:0] row_data_t;
  typedef logic [ADDR_BITS-1:0]     addr_t;
  typedef logic [BANK_BITS-1:0]     bank_t;
  typedef logic [ROW_BITS-1:0]      row_t;
  typedef logic [WORD_BITS-1:0]     word_t;
  typedef logic [PADR_BITS-1:0]     padr_t;  // {bank, row, word}

endpackage
